//--- Makefile
# Verilator lint and simulation of the blocking data cache

VERILATOR  ?= verilator
FILELIST   ?= sources.f
TB_TOP     ?= cache_tb
RTL_TOP    ?= cache_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "failure reported in $(LOG)"; exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/cache_tb_table.svh
// request table that the cache testbench includes inside its module
// columns are name, type, address, write data and expected response data
task automatic build_table();
  // ----------------------------------------
  // reads after reset see all-zero memory
  // ----------------------------------------
  add_entry("read_fresh_040", cache_pkg::mem_read, 32'h040, 32'h0, 32'h0);
  add_entry("read_fresh_3fc", cache_pkg::mem_read, 32'h3fc, 32'h0, 32'h0);

  // write and write-init, then read back
  add_entry("write_010", cache_pkg::mem_write, 32'h010, 32'hdeadbeef, 32'h0);
  add_entry("read_010", cache_pkg::mem_read, 32'h010, 32'h0, 32'hdeadbeef);
  add_entry("init_024", cache_pkg::mem_write_init, 32'h024, 32'h12345678, 32'h0);
  add_entry("read_024", cache_pkg::mem_read, 32'h024, 32'h0, 32'h12345678);
  // neighbour word filled by the refill
  add_entry("read_020", cache_pkg::mem_read, 32'h020, 32'h0, 32'h0);

  // ----------------------------------------
  // four tags on index 0 where each evicts the last
  // ----------------------------------------
  add_entry("write_000", cache_pkg::mem_write, 32'h000, 32'h11111111, 32'h0);
  add_entry("write_100", cache_pkg::mem_write, 32'h100, 32'h22222222, 32'h0);
  add_entry("write_200", cache_pkg::mem_write, 32'h200, 32'h33333333, 32'h0);
  add_entry("write_300", cache_pkg::mem_write, 32'h300, 32'h44444444, 32'h0);
  add_entry("read_000", cache_pkg::mem_read, 32'h000, 32'h0, 32'h11111111);
  add_entry("read_100", cache_pkg::mem_read, 32'h100, 32'h0, 32'h22222222);
  add_entry("read_200", cache_pkg::mem_read, 32'h200, 32'h0, 32'h33333333);
  add_entry("read_300", cache_pkg::mem_read, 32'h300, 32'h0, 32'h44444444);

  // ----------------------------------------
  // amos return the old word
  // ----------------------------------------
  add_entry("write_0a0", cache_pkg::mem_write, 32'h0a0, 32'h00f00f0f, 32'h0);
  add_entry("amo_or_0a0", cache_pkg::mem_amo_or, 32'h0a0, 32'h0000f0f0, 32'h00f00f0f);
  add_entry("read_or_0a0", cache_pkg::mem_read, 32'h0a0, 32'h0,
            32'h00f00f0f | 32'h0000f0f0);
  add_entry("amo_and_0a0", cache_pkg::mem_amo_and, 32'h0a0, 32'hff00ff00,
            32'h00f00f0f | 32'h0000f0f0);
  add_entry("read_and_0a0", cache_pkg::mem_read, 32'h0a0, 32'h0,
            (32'h00f00f0f | 32'h0000f0f0) & 32'hff00ff00);
  add_entry("write_0b8", cache_pkg::mem_write, 32'h0b8, 32'h7ffffff0, 32'h0);
  add_entry("amo_add_0b8", cache_pkg::mem_amo_add, 32'h0b8, 32'h00000025, 32'h7ffffff0);
  add_entry("read_add_0b8", cache_pkg::mem_read, 32'h0b8, 32'h0,
            32'h7ffffff0 + 32'h00000025);
  // amo on a line never touched sees an old value of zero
  add_entry("amo_add_ffc", cache_pkg::mem_amo_add, 32'hffc, 32'h00000005, 32'h0);
  add_entry("read_add_ffc", cache_pkg::mem_read, 32'hffc, 32'h0, 32'h0 + 32'h00000005);

  // push the amo line out and bring it back
  add_entry("write_5a0", cache_pkg::mem_write, 32'h5a0, 32'hcafef00d, 32'h0);
  add_entry("reread_0a0", cache_pkg::mem_read, 32'h0a0, 32'h0,
            (32'h00f00f0f | 32'h0000f0f0) & 32'hff00ff00);
  add_entry("read_5a0", cache_pkg::mem_read, 32'h5a0, 32'h0, 32'hcafef00d);
  add_entry("reread_0b8", cache_pkg::mem_read, 32'h0b8, 32'h0,
            32'h7ffffff0 + 32'h00000025);
  add_entry("reread_010", cache_pkg::mem_read, 32'h010, 32'h0, 32'hdeadbeef);
endtask

//--- bench/cache_tb.sv
// testbench for cache_top that walks the request table with random gaps and back-pressure
// and checks each response in order against the table's expected values
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

  logic                   clk;
  logic                   rst;
  logic                   cachereq_val;
  logic                   cachereq_rdy;
  cache_pkg::cache_req_t  cachereq_msg;
  logic                   cacheresp_val;
  logic                   cacheresp_rdy;
  cache_pkg::cache_resp_t cacheresp_msg;

  // table columns that build_table fills
  string                  names [$];
  cache_pkg::cache_req_t  reqs  [$];
  cache_pkg::cache_resp_t exps  [$];

  int          n_pass;
  int          n_fail;
  int          drv_idx;
  int          chk_idx;
  int          gap;
  int          cycles;
  int          limit;
  logic        req_fire;
  logic [15:0] lfsr;

  cache_top dut (
    .clk           (clk),
    .rst           (rst),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cachereq_msg  (cachereq_msg),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .cacheresp_msg (cacheresp_msg)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // ----------------------------------------
  // table and random helpers
  // ----------------------------------------

  task automatic add_entry(input string name, input cache_pkg::mem_type_e kind,
                           input logic [31:0] addr, input logic [31:0] data,
                           input logic [31:0] exp_data);
    cache_pkg::cache_req_t  req;
    cache_pkg::cache_resp_t exp;
    req.msg_type = kind;
    // opaque differs from entry to entry so echo errors show up
    req.opaque   = 8'(names.size() * 37 + 5);
    req.addr     = addr;
    req.len      = 2'd0;
    req.data     = data;
    exp.msg_type = kind;
    exp.opaque   = req.opaque;
    exp.len      = 2'd0;
    exp.data     = exp_data;
    names.push_back(name);
    reqs.push_back(req);
    exps.push_back(exp);
  endtask

  `include "cache_tb_table.svh"

  // galois lfsr over x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic int lfsr_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      v    = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
    end
    return v;
  endfunction

  // ----------------------------------------
  // compare
  // ----------------------------------------

  function automatic string resp_text(input cache_pkg::cache_resp_t r);
    return $sformatf("type %0d opaque %02h len %0d data %08h",
                     r.msg_type, r.opaque, r.len, r.data);
  endfunction

  task automatic check_resp(input string name, input cache_pkg::cache_resp_t exp,
                            input cache_pkg::cache_resp_t act);
    if (act === exp)
    begin
      n_pass++;
      $display("ok %s %s", name, resp_text(act));
    end
    else
    begin
      n_fail++;
      $display("mismatch %s expected %s actual %s", name, resp_text(exp), resp_text(act));
    end
  endtask

  // ----------------------------------------
  // per-cycle driver and checker at negedge
  // ----------------------------------------

  task automatic drive_request();
    // val and rdy seen together last negedge, so it went in at the posedge
    if (req_fire)
    begin
      cachereq_val = 1'b0;
      drv_idx++;
      gap      = lfsr_bits(2);
      req_fire = 1'b0;
    end
    if (!cachereq_val && drv_idx < names.size())
    begin
      if (gap > 0)
        gap--;
      else
      begin
        cachereq_val = 1'b1;
        cachereq_msg = reqs[drv_idx];
      end
    end
    // rdy is state based and stable here
    req_fire = cachereq_val && cachereq_rdy;
    // one request in flight, so every earlier response must be taken
    if (req_fire && chk_idx != drv_idx)
    begin
      n_fail++;
      $display("request %s was accepted before the previous response was taken",
               names[drv_idx]);
    end
  endtask

  task automatic collect_response();
    // ready three cycles out of four on average
    cacheresp_rdy = (lfsr_bits(2) != 0);
    if (cacheresp_val && cacheresp_rdy)
    begin
      check_resp(names[chk_idx], exps[chk_idx], cacheresp_msg);
      chk_idx++;
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial
  begin
    clk           = 1'b0;
    rst           = 1'b1;
    cachereq_val  = 1'b0;
    cachereq_msg  = '0;
    cacheresp_rdy = 1'b0;
    n_pass        = 0;
    n_fail        = 0;
    drv_idx       = 0;
    chk_idx       = 0;
    gap           = 0;
    cycles        = 0;
    req_fire      = 1'b0;
    lfsr          = 16'd31887;
    build_table();
    // worst case is a dirty miss plus gaps and stalls
    limit = names.size() * 24 + 50;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (!cachereq_rdy || cacheresp_val)
    begin
      n_fail++;
      $display("after reset cachereq_rdy is %b and cacheresp_val is %b, expected 1 and 0",
               cachereq_rdy, cacheresp_val);
    end
    while (chk_idx < names.size() && cycles < limit)
    begin
      drive_request();
      collect_response();
      @(negedge clk);
      cycles++;
    end
    if (chk_idx < names.size())
    begin
      n_fail++;
      $display("timed out waiting for a response to %s after %0d cycles",
               names[chk_idx], cycles);
    end
    $display("tests %0d passed %0d failed %0d", names.size(), n_pass, n_fail);
    if (n_fail == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/cache_array.sv
// tag, valid, dirty and data storage for the direct-mapped cache
// combinational read at index, writes land on the next clock edge
`timescale 1ns/1ps
`default_nettype none

module cache_array (
  input  wire                                 clk,
  input  wire                                 rst,
  input  wire  [cache_pkg::c_index_nbits-1:0] index,
  input  wire                                 tag_we,
  input  wire                                 data_we,
  input  wire  [cache_pkg::c_tag_nbits-1:0]   tag_wdata,
  input  wire                                 dirty_wdata,
  input  wire  cache_pkg::line_u              line_wdata,
  output logic [cache_pkg::c_tag_nbits-1:0]   tag,
  output logic                                valid,
  output logic                                dirty,
  output cache_pkg::line_u                    line
);

  logic [cache_pkg::c_tag_nbits-1:0]    tags  [cache_pkg::c_cache_nlines];
  cache_pkg::line_u                     lines [cache_pkg::c_cache_nlines];
  logic [cache_pkg::c_cache_nlines-1:0] valid_r;
  logic [cache_pkg::c_cache_nlines-1:0] dirty_r;

  // ----------------------------------------
  // read side
  // ----------------------------------------

  assign tag   = tags[index];
  assign valid = valid_r[index];
  assign dirty = dirty_r[index];
  assign line  = lines[index];

  // ----------------------------------------
  // state bits
  // ----------------------------------------

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_r <= '0;
      dirty_r <= '0;
    end
    else
    begin
      // a new tag always means a live line
      if (tag_we)
        valid_r[index] <= 1'b1;
      // refill clears dirty, a store sets it
      if (tag_we || data_we)
        dirty_r[index] <= dirty_wdata;
    end
  end

  // tag and line payload
  always_ff @(posedge clk)
  begin
    if (tag_we)
      tags[index] <= tag_wdata;
    if (data_we)
      lines[index] <= line_wdata;
  end

  // controller only stores into a live line or one it installs now
  assert property (@(posedge clk) disable iff (rst)
    data_we |-> valid_r[index] || tag_we);

endmodule

`default_nettype wire

//--- source/cache_ctrl.sv
// blocking cache controller with one request in flight at a time
// runs tag check, amo merge, writeback, refill and the response handshake
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
  input  wire                                    clk,
  input  wire                                    rst,
  // processor side
  input  wire                                    cachereq_val,
  output logic                                   cachereq_rdy,
  input  wire  cache_pkg::cache_req_t            cachereq_msg,
  output logic                                   cacheresp_val,
  input  wire                                    cacheresp_rdy,
  output cache_pkg::cache_resp_t                 cacheresp_msg,
  // backing memory side
  output logic                                   memreq_val,
  input  wire                                    memreq_rdy,
  output cache_pkg::mem_req_t                    memreq_msg,
  input  wire                                    memresp_val,
  input  wire  cache_pkg::mem_resp_t             memresp_msg,
  // line array that answers in the same cycle
  output logic [cache_pkg::c_index_nbits-1:0]    arr_index,
  output logic                                   arr_tag_we,
  output logic                                   arr_data_we,
  output logic [cache_pkg::c_tag_nbits-1:0]      arr_tag_wdata,
  output logic                                   arr_dirty_wdata,
  output cache_pkg::line_u                       arr_line_wdata,
  input  wire  [cache_pkg::c_tag_nbits-1:0]      arr_tag,
  input  wire                                    arr_valid,
  input  wire                                    arr_dirty,
  input  wire  cache_pkg::line_u                 arr_line
);

  typedef enum logic [2:0] {
    idle, tag_check, evict_req, refill_req, refill_wait, resp
  } state_e;

  state_e                                             state;
  state_e                                             state_nxt;
  cache_pkg::cache_req_t                              req_r;
  cache_pkg::cache_resp_t                             resp_r;
  logic [cache_pkg::c_tag_nbits-1:0]                  req_tag;
  logic [cache_pkg::c_index_nbits-1:0]                req_index;
  logic [$clog2(cache_pkg::c_words_per_line)-1:0]     req_word;
  logic                                               hit;
  logic                                               modify;
  logic                                               need_evict;
  logic [cache_pkg::c_word_nbits-1:0]                 old_word;
  logic [cache_pkg::c_word_nbits-1:0]                 new_word;
  cache_pkg::line_u                                   merged;

  // ----------------------------------------
  // address split and tag compare
  // ----------------------------------------

  assign req_tag    = req_r.addr[cache_pkg::c_offset_nbits + cache_pkg::c_index_nbits
                                 +: cache_pkg::c_tag_nbits];
  assign req_index  = req_r.addr[cache_pkg::c_offset_nbits +: cache_pkg::c_index_nbits];
  assign req_word   = req_r.addr[cache_pkg::c_offset_nbits-1
                                 -: $clog2(cache_pkg::c_words_per_line)];
  assign hit        = arr_valid && (arr_tag == req_tag);
  // victim only matters on a miss
  assign need_evict = arr_valid && arr_dirty;
  assign modify     = (req_r.msg_type != cache_pkg::mem_read);
  assign old_word   = arr_line.words[req_word];

  // ----------------------------------------
  // word merge for writes and amos
  // ----------------------------------------

  always_comb
  begin
    case (req_r.msg_type)
      cache_pkg::mem_amo_add: new_word = old_word + req_r.data;
      cache_pkg::mem_amo_and: new_word = old_word & req_r.data;
      cache_pkg::mem_amo_or:  new_word = old_word | req_r.data;
      // write and write-init store the request word as is
      default:                new_word = req_r.data;
    endcase
    merged = arr_line;
    merged.words[req_word] = new_word;
  end

  // ----------------------------------------
  // fsm
  // ----------------------------------------

  always_comb
  begin
    state_nxt = state;
    case (state)
      idle:
        if (cachereq_val)
          state_nxt = tag_check;
      tag_check:
        // clean miss sends the refill read from here
        if (hit)
          state_nxt = resp;
        else if (need_evict)
          state_nxt = evict_req;
        else if (memreq_rdy)
          state_nxt = refill_wait;
      evict_req:
        if (memreq_rdy)
          state_nxt = refill_req;
      refill_req:
        if (memreq_rdy)
          state_nxt = refill_wait;
      refill_wait:
        // installed line hits on the second tag check
        if (memresp_val)
          state_nxt = tag_check;
      resp:
        if (cacheresp_rdy)
          state_nxt = idle;
      default:
        state_nxt = idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= idle;
    else
      state <= state_nxt;
  end

  // request latch and response word
  always_ff @(posedge clk)
  begin
    if (cachereq_val && cachereq_rdy)
      req_r <= cachereq_msg;
    if (state == tag_check && hit)
    begin
      resp_r.msg_type <= req_r.msg_type;
      resp_r.opaque   <= req_r.opaque;
      resp_r.len      <= req_r.len;
      // reads and amos return the old word and plain writes return zero
      if (req_r.msg_type == cache_pkg::mem_write || req_r.msg_type == cache_pkg::mem_write_init)
        resp_r.data <= '0;
      else
        resp_r.data <= old_word;
    end
  end

  assign cachereq_rdy  = (state == idle);
  assign cacheresp_val = (state == resp);
  assign cacheresp_msg = resp_r;

  // ----------------------------------------
  // memory port and array writes
  // ----------------------------------------

  always_comb
  begin
    memreq_val           = 1'b0;
    memreq_msg.write     = 1'b0;
    memreq_msg.line_addr = {req_tag, req_index};
    memreq_msg.data      = arr_line;
    case (state)
      tag_check:
        memreq_val = !hit && !need_evict;
      evict_req:
      begin
        // old line goes back under its own tag
        memreq_val           = 1'b1;
        memreq_msg.write     = 1'b1;
        memreq_msg.line_addr = {arr_tag, req_index};
      end
      refill_req:
        memreq_val = 1'b1;
      default:
        memreq_val = 1'b0;
    endcase
  end

  always_comb
  begin
    arr_index       = req_index;
    arr_tag_we      = 1'b0;
    arr_data_we     = 1'b0;
    arr_tag_wdata   = req_tag;
    arr_dirty_wdata = 1'b0;
    arr_line_wdata  = merged;
    if (state == refill_wait && memresp_val)
    begin
      // clean install of the fetched line
      arr_tag_we     = 1'b1;
      arr_data_we    = 1'b1;
      arr_line_wdata = memresp_msg.data;
    end
    else if (state == tag_check && hit && modify)
    begin
      arr_data_we     = 1'b1;
      arr_dirty_wdata = 1'b1;
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------

  // whole aligned words inside the 4 KB space only
  assert property (@(posedge clk) disable iff (rst)
    cachereq_val && cachereq_rdy |->
      cachereq_msg.len == '0
      && cachereq_msg.addr[$clog2(cache_pkg::c_word_nbits/8)-1:0] == '0
      && (cachereq_msg.addr >> cache_pkg::c_addr_used_nbits) == '0);

  // stalled response stays put until taken
  assert property (@(posedge clk) disable iff (rst)
    cacheresp_val && !cacheresp_rdy |=> cacheresp_val && $stable(cacheresp_msg));

endmodule

`default_nettype wire

//--- source/cache_pkg.sv
// shared constants and message types for the cache and its line memory
// referenced by scoped name from every design file
`default_nettype none

package cache_pkg;

  // ----------------------------------------
  // geometry
  // ----------------------------------------

  localparam int c_word_nbits      = 32;
  localparam int c_line_nbits      = 128;
  localparam int c_words_per_line  = 4;
  localparam int c_opaque_nbits    = 8;

  // 256 byte cache as 16 lines of 16 bytes
  localparam int c_cache_nlines    = 16;
  localparam int c_offset_nbits    = 4;
  // index from addr 7:4 and tag from addr 11:8
  localparam int c_index_nbits     = 4;
  localparam int c_tag_nbits       = 4;

  // 4 KB backing store
  localparam int c_mem_nlines      = 256;
  localparam int c_addr_used_nbits = 12;

  // ----------------------------------------
  // message types
  // ----------------------------------------

  // same encoding in both directions
  typedef enum logic [2:0] {
    mem_read       = 3'd0,
    mem_write      = 3'd1,
    mem_write_init = 3'd2,
    mem_amo_add    = 3'd3,
    mem_amo_and    = 3'd4,
    mem_amo_or     = 3'd5
  } mem_type_e;

  // processor side request with the type in the msbs
  typedef struct packed {
    mem_type_e                 msg_type;
    logic [c_opaque_nbits-1:0] opaque;
    logic [31:0]               addr;
    logic [1:0]                len;
    logic [c_word_nbits-1:0]   data;
  } cache_req_t;

  typedef struct packed {
    mem_type_e                 msg_type;
    logic [c_opaque_nbits-1:0] opaque;
    logic [1:0]                len;
    logic [c_word_nbits-1:0]   data;
  } cache_resp_t;

  // whole line for refill and writeback, word view for hits and amos
  // word 0 sits in the low bits
  typedef union packed {
    logic [c_line_nbits-1:0]                         line;
    logic [c_words_per_line-1:0][c_word_nbits-1:0]   words;
  } line_u;

  // memory side carries one line per transfer
  typedef struct packed {
    logic                              write;
    logic [$clog2(c_mem_nlines)-1:0]   line_addr;
    line_u                             data;
  } mem_req_t;

  typedef struct packed {
    line_u data;
  } mem_resp_t;

endpackage

`default_nettype wire

//--- source/cache_top.sv
// cache with its backing memory as the unit that the testbench drives
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          cachereq_val,
  output logic                         cachereq_rdy,
  input  wire  cache_pkg::cache_req_t  cachereq_msg,
  output logic                         cacheresp_val,
  input  wire                          cacheresp_rdy,
  output cache_pkg::cache_resp_t       cacheresp_msg
);

  // ----------------------------------------
  // controller to memory
  // ----------------------------------------

  logic                 memreq_val;
  logic                 memreq_rdy;
  cache_pkg::mem_req_t  memreq_msg;
  logic                 memresp_val;
  cache_pkg::mem_resp_t memresp_msg;

  // controller to array
  logic [cache_pkg::c_index_nbits-1:0] arr_index;
  logic                                arr_tag_we;
  logic                                arr_data_we;
  logic [cache_pkg::c_tag_nbits-1:0]   arr_tag_wdata;
  logic                                arr_dirty_wdata;
  cache_pkg::line_u                    arr_line_wdata;
  logic [cache_pkg::c_tag_nbits-1:0]   arr_tag;
  logic                                arr_valid;
  logic                                arr_dirty;
  cache_pkg::line_u                    arr_line;

  cache_ctrl u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .cachereq_val    (cachereq_val),
    .cachereq_rdy    (cachereq_rdy),
    .cachereq_msg    (cachereq_msg),
    .cacheresp_val   (cacheresp_val),
    .cacheresp_rdy   (cacheresp_rdy),
    .cacheresp_msg   (cacheresp_msg),
    .memreq_val      (memreq_val),
    .memreq_rdy      (memreq_rdy),
    .memreq_msg      (memreq_msg),
    .memresp_val     (memresp_val),
    .memresp_msg     (memresp_msg),
    .arr_index       (arr_index),
    .arr_tag_we      (arr_tag_we),
    .arr_data_we     (arr_data_we),
    .arr_tag_wdata   (arr_tag_wdata),
    .arr_dirty_wdata (arr_dirty_wdata),
    .arr_line_wdata  (arr_line_wdata),
    .arr_tag         (arr_tag),
    .arr_valid       (arr_valid),
    .arr_dirty       (arr_dirty),
    .arr_line        (arr_line)
  );

  cache_array u_array (
    .clk         (clk),
    .rst         (rst),
    .index       (arr_index),
    .tag_we      (arr_tag_we),
    .data_we     (arr_data_we),
    .tag_wdata   (arr_tag_wdata),
    .dirty_wdata (arr_dirty_wdata),
    .line_wdata  (arr_line_wdata),
    .tag         (arr_tag),
    .valid       (arr_valid),
    .dirty       (arr_dirty),
    .line        (arr_line)
  );

  // fixed latency store that reset clears
  line_mem u_mem (
    .clk         (clk),
    .rst         (rst),
    .memreq_val  (memreq_val),
    .memreq_rdy  (memreq_rdy),
    .memreq_msg  (memreq_msg),
    .memresp_val (memresp_val),
    .memresp_msg (memresp_msg)
  );

endmodule

`default_nettype wire

//--- source/line_mem.sv
// backing store of whole 128-bit lines behind the cache
// reads answer one cycle after acceptance and writes are silent
`timescale 1ns/1ps
`default_nettype none

module line_mem (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       memreq_val,
  output logic                      memreq_rdy,
  input  wire  cache_pkg::mem_req_t memreq_msg,
  output logic                      memresp_val,
  output cache_pkg::mem_resp_t      memresp_msg
);

  logic [cache_pkg::c_line_nbits-1:0] mem [cache_pkg::c_mem_nlines];
  // marks lines written since reset so the rest read as zero
  logic [cache_pkg::c_mem_nlines-1:0] written;
  logic                               resp_pending;
  logic                               accept;

  // ----------------------------------------
  // handshake
  // ----------------------------------------

  // busy only while a read answer is out
  assign memreq_rdy  = !resp_pending;
  assign memresp_val = resp_pending;
  assign accept      = memreq_val && memreq_rdy;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      resp_pending <= 1'b0;
      written      <= '0;
    end
    else
    begin
      resp_pending <= accept && !memreq_msg.write;
      if (accept && memreq_msg.write)
        written[memreq_msg.line_addr] <= 1'b1;
    end
  end

  // ----------------------------------------
  // storage and read data
  // ----------------------------------------

  always_ff @(posedge clk)
  begin
    if (accept && memreq_msg.write)
      mem[memreq_msg.line_addr] <= memreq_msg.data.line;
    if (accept && !memreq_msg.write)
    begin
      if (written[memreq_msg.line_addr])
        memresp_msg.data.line <= mem[memreq_msg.line_addr];
      else
        memresp_msg.data.line <= '0;
    end
  end

  // requester waits for the answer before sending again
  assert property (@(posedge clk) disable iff (rst)
    memreq_val |-> !resp_pending);

endmodule

`default_nettype wire

//--- sources.f
+incdir+bench
source/cache_pkg.sv
source/cache_array.sv
source/line_mem.sv
source/cache_ctrl.sv
source/cache_top.sv
bench/cache_tb.sv
